// ==== tb/glitc_core_tests.txt ====
# W addr data | R addr expected_rdata (all hex)
# S lower_power upper_power lower_corr upper_corr valid expected_trigger (all hex)
R 00 14060600
R 10 00000000
R 65 00000000
W 01 a5a55a5a
W 01 0badcafe
R 01 0badcafe
W 70 00000100
W 71 00000200
R 70 00000100
R 71 00000200
S 101 200 05 0a 1 1
S 100 201 11 22 1 2
S fff fff 3f 3f 0 0
S 0ff 1ff 01 02 1 0
S 200 300 07 2a 1 3
S 150 100 0c 03 1 1
R 72 00000000
W 02 00000002
R 72 00000003
R 73 00000002
R 74 0000030c
W 02 00000001
R 72 00000000
R 73 00000000
R 74 00000000
R 70 00000100
R 71 00000200

// ==== list.f ====
+incdir+design
design/glitc_pkg.sv
design/glitc_user_bus_if.sv
design/glitcbus_slave.sv
design/glitc_control_registers.sv
design/glitc_trigger.sv
design/glitc_core.sv
tb/glitc_core_props.sv
tb/glitc_core_tb.sv

// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --binary --timing --assert -Wno-fatal
TOP       := glitc_core_tb
FILELIST  := list.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard design/*.sv design/*.svh tb/*.sv) $(FILELIST)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes.
$(SIM): $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/glitc_core_tb.sv ====
//////////////////////////////////////////////////
// Run from the project root. Each line of the
// test file is one test, a bus access or a
// sector sample. Lines starting with # are skipped.
//////////////////////////////////////////////////
`timescale 1ns/1ps

module glitc_core_tb;

	localparam int CYCLES_PER_TEST = 20;
	localparam int RESET_CYCLES    = 3;

	// Fields are hex columns from the test file.
	typedef struct packed {
		logic [7:0]       kind;
		logic [5:0][31:0] f;
	} test_t;

	logic        user_clk_i;
	logic        reset_i;
	logic        req_i;
	logic        wr_i;
	logic [7:0]  addr_i;
	logic [31:0] wdata_i;
	logic        ack_o;
	logic [31:0] rdata_o;
	logic [11:0] lower_power_i;
	logic [11:0] upper_power_i;
	logic [5:0]  lower_corr_i;
	logic [5:0]  upper_corr_i;
	logic        sector_valid_i;
	logic [1:0]  trigger_o;

	test_t       tests[$];
	int          n_pass;
	int          n_fail;
	int          cycle_limit;
	logic [31:0] rng_state;

	glitc_core glitc_core_i (.*);

	initial begin
		user_clk_i = 1'b0;
		forever #4 user_clk_i = ~user_clk_i;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic load_tests(output bit ok);
		int    fd;
		int    n;
		string line;
		byte   kind;
		logic [31:0] v0, v1, v2, v3, v4, v5;
		test_t t;
		fd = $fopen("tb/glitc_core_tests.txt", "r");
		ok = (fd != 0);
		if (fd != 0) begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				if (n > 0 && line.len() > 1 && line[0] != "#") begin
					n = $sscanf(line, "%c %h %h %h %h %h %h", kind, v0, v1, v2, v3, v4, v5);
					t.kind = kind;
					t.f = {v5, v4, v3, v2, v1, v0};
					tests.push_back(t);
				end
			end
			$fclose(fd);
		end
	endtask

	//////////////////////////////////////////////////
	// Four-phase host access with a random idle gap.
	//////////////////////////////////////////////////
	task automatic bus_access(input logic wr, input logic [31:0] addr,
			input logic [31:0] data, output logic [31:0] rdata);
		int gap;
		rng_state = xorshift32(rng_state);
		gap = int'(rng_state[1:0]);
		repeat (gap) @(posedge user_clk_i);
		@(posedge user_clk_i);
		req_i   <= 1'b1;
		wr_i    <= wr;
		addr_i  <= addr[7:0];
		wdata_i <= data;
		@(negedge user_clk_i);
		while (ack_o !== 1'b1) @(negedge user_clk_i);
		rdata = rdata_o;
		@(posedge user_clk_i);
		req_i <= 1'b0;
		@(negedge user_clk_i);
		while (ack_o !== 1'b0) @(negedge user_clk_i);
	endtask

	// Sector inputs are valid for one cycle only.
	task automatic sector_sample(input test_t t, output logic [1:0] trig);
		@(posedge user_clk_i);
		lower_power_i  <= t.f[0][11:0];
		upper_power_i  <= t.f[1][11:0];
		lower_corr_i   <= t.f[2][5:0];
		upper_corr_i   <= t.f[3][5:0];
		sector_valid_i <= t.f[4][0];
		@(posedge user_clk_i);
		sector_valid_i <= 1'b0;
		@(negedge user_clk_i);
		trig = trigger_o;
	endtask

	initial begin
		int cycles;
		cycles = 0;
		wait (cycle_limit > 0);
		while (cycles < cycle_limit) begin
			@(posedge user_clk_i);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
		$display("Test failures found");
		$finish;
	end

	initial begin
		bit          loaded;
		bit          ok;
		logic [31:0] got;
		rng_state      = 32'd23;
		n_pass         = 0;
		n_fail         = 0;
		reset_i        = 1'b1;
		req_i          = 1'b0;
		wr_i           = 1'b0;
		addr_i         = '0;
		wdata_i        = '0;
		lower_power_i  = '0;
		upper_power_i  = '0;
		lower_corr_i   = '0;
		upper_corr_i   = '0;
		sector_valid_i = 1'b0;
		load_tests(loaded);
		if (!loaded) begin
			$display("Could not open the test file tb/glitc_core_tests.txt");
			n_fail++;
		end else begin
			cycle_limit = tests.size() * CYCLES_PER_TEST + RESET_CYCLES + 10;
		end
		repeat (RESET_CYCLES) @(posedge user_clk_i);
		reset_i <= 1'b0;

		foreach (tests[i]) begin
			ok  = 1'b1;
			got = '0;
			case (tests[i].kind)
				"W": bus_access(1'b1, tests[i].f[0], tests[i].f[1], got);
				"R": begin
					bus_access(1'b0, tests[i].f[0], 32'h0, got);
					assert (got === tests[i].f[1]) else begin
						$display("[ERROR] %0t: read 0x%02h returned 0x%08h, expected 0x%08h",
							$time, tests[i].f[0][7:0], got, tests[i].f[1]);
						ok = 1'b0;
					end
				end
				"S": begin
					sector_sample(tests[i], got[1:0]);
					assert (got[1:0] === tests[i].f[5][1:0]) else begin
						$display("[ERROR] %0t: trigger_o is %b, expected %b",
							$time, got[1:0], tests[i].f[5][1:0]);
						ok = 1'b0;
					end
				end
				default: begin
					$display("Test %0d has an unknown kind and was not run", i);
					ok = 1'b0;
				end
			endcase
			if (ok) n_pass++;
			else n_fail++;
			$display("test %0d (%c): %s", i, tests[i].kind, ok ? "ok" : "FAILED");
		end

		$display("Summary: %0d tests, %0d passed, %0d failed, %0d property failures",
			tests.size(), n_pass, n_fail, glitc_core_i.props_i.fail_count);
		if (n_fail == 0 && n_pass > 0 && glitc_core_i.props_i.fail_count == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// ==== tb/glitc_core_props.sv ====
//////////////////////////////////////////////////
// Handshake and reset properties, bound into the
// top level of the design.
//////////////////////////////////////////////////
`timescale 1ns/1ps

module glitc_core_props (
	input logic       user_clk_i,
	input logic       reset_i,
	input logic       req_i,
	input logic       ack_o,
	input logic [1:0] trigger_o
);

	// Number of property failures so far.
	int fail_count = 0;

	// Ack only rises while the host holds a request.
	ack_rise_a: assert property (@(posedge user_clk_i) disable iff (reset_i)
		$rose(ack_o) |-> req_i)
		else begin
			fail_count++;
			$error("ack_o rose while req_i was low");
		end

	// Ack falls only once the host has dropped req.
	ack_fall_a: assert property (@(posedge user_clk_i) disable iff (reset_i)
		$fell(ack_o) |-> (!req_i && !$past(req_i)))
		else begin
			fail_count++;
			$error("ack_o fell before req_i was released");
		end

	reset_a: assert property (@(posedge user_clk_i)
		reset_i |=> (!ack_o && (trigger_o == 2'b00)))
		else begin
			fail_count++;
			$error("ack_o or trigger_o not low after reset");
		end

endmodule

bind glitc_core glitc_core_props props_i (
	.user_clk_i (user_clk_i),
	.reset_i    (reset_i),
	.req_i      (req_i),
	.ack_o      (ack_o),
	.trigger_o  (trigger_o)
);

// ==== design/glitc_core.sv ====
//////////////////////////////////////////////////
// Single clock domain. Host side uses a
// four-phase req/ack handshake.
//////////////////////////////////////////////////
`timescale 1ns/1ps

module glitc_core import glitc_pkg::*; (
	input  logic       user_clk_i,
	input  logic       reset_i,
	// Host register bus.
	input  logic       req_i,
	input  logic       wr_i,
	input  user_addr_t addr_i,
	input  user_data_t wdata_i,
	output logic       ack_o,
	output user_data_t rdata_o,
	// Sector inputs from the correlator.
	input  power_t     lower_power_i,
	input  corr_t      lower_corr_i,
	input  power_t     upper_power_i,
	input  corr_t      upper_corr_i,
	input  logic       sector_valid_i,
	output logic [1:0] trigger_o
);

	logic soft_reset;
	logic hsk_update;

	glitc_user_bus_if bus_if ();

	glitcbus_slave u_slave (
		.user_clk_i (user_clk_i),
		.reset_i    (reset_i),
		.req_i      (req_i),
		.wr_i       (wr_i),
		.addr_i     (addr_i),
		.wdata_i    (wdata_i),
		.ack_o      (ack_o),
		.rdata_o    (rdata_o),
		.bus        (bus_if.slave)
	);

	glitc_control_registers u_control (
		.user_clk_i   (user_clk_i),
		.reset_i      (reset_i),
		.bus          (bus_if.ctrl),
		.soft_reset_o (soft_reset),
		.hsk_update_o (hsk_update)
	);

	glitc_trigger u_trigger (
		.user_clk_i     (user_clk_i),
		.reset_i        (reset_i),
		.bus            (bus_if.trigger),
		.soft_reset_i   (soft_reset),
		.hsk_update_i   (hsk_update),
		.lower_power_i  (lower_power_i),
		.upper_power_i  (upper_power_i),
		.lower_corr_i   (lower_corr_i),
		.upper_corr_i   (upper_corr_i),
		.sector_valid_i (sector_valid_i),
		.trigger_o      (trigger_o)
	);

endmodule

// ==== design/glitc_trigger.sv ====
//////////////////////////////////////////////////
// Index 0 is the lower sector, index 1 the upper.
// Soft reset leaves the thresholds alone.
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "glitc_config.svh"

module glitc_trigger import glitc_pkg::*; (
	input  logic       user_clk_i,
	input  logic       reset_i,
	glitc_user_bus_if.trigger bus,
	input  logic       soft_reset_i,
	input  logic       hsk_update_i,
	input  power_t     lower_power_i,
	input  power_t     upper_power_i,
	input  corr_t      lower_corr_i,
	input  corr_t      upper_corr_i,
	input  logic       sector_valid_i,
	output logic [1:0] trigger_o
);

	localparam logic [3:0] REG_LOWER_THRESH = 4'd0;
	localparam logic [3:0] REG_UPPER_THRESH = 4'd1;
	localparam logic [3:0] REG_LOWER_SCALER = 4'd2;
	localparam logic [3:0] REG_UPPER_SCALER = 4'd3;
	localparam logic [3:0] REG_LAST_CORR    = 4'd4;
	localparam scaler_t    SCALER_MAX       = '1;

	power_t  [1:0] power_now;
	corr_t   [1:0] corr_now;
	power_t  [1:0] threshold;
	scaler_t [1:0] running;
	scaler_t [1:0] latched;
	corr_t   [1:0] last_corr;
	logic    [1:0] trig_now;
	user_data_t    rdata;

	assign power_now = {upper_power_i, lower_power_i};
	assign corr_now  = {upper_corr_i, lower_corr_i};

	always_comb begin
		for (int s = 0; s < 2; s++) begin
			trig_now[s] = sector_valid_i && (power_now[s] > threshold[s]);
		end
	end

	always_ff @(posedge user_clk_i) begin
		if (reset_i) begin
			trigger_o <= '0;
			threshold <= '0;
		end else begin
			trigger_o <= trig_now;
			if (bus.sel_trigger && bus.wr && (bus.reg_addr == REG_LOWER_THRESH))
				threshold[0] <= bus.wdata[`GLITC_POWER_W-1:0];
			if (bus.sel_trigger && bus.wr && (bus.reg_addr == REG_UPPER_THRESH))
				threshold[1] <= bus.wdata[`GLITC_POWER_W-1:0];
		end
	end

	//////////////////////////////////////////////////
	// Scalers and last correlation.
	//////////////////////////////////////////////////
	always_ff @(posedge user_clk_i) begin
		if (reset_i || soft_reset_i) begin
			running   <= '0;
			latched   <= '0;
			last_corr <= '0;
		end else begin
			for (int s = 0; s < 2; s++) begin
				if (hsk_update_i) begin
					// Count from this cycle carries into the new interval.
					latched[s] <= running[s];
					running[s] <= scaler_t'(trig_now[s]);
				end else if (trig_now[s] && (running[s] != SCALER_MAX)) begin
					running[s] <= running[s] + 1'b1;
				end
			end
			if (|trig_now) begin
				last_corr <= corr_now;
			end
		end
	end

	always_comb begin
		rdata = '0;
		case (bus.reg_addr)
			REG_LOWER_THRESH: rdata[`GLITC_POWER_W-1:0] = threshold[0];
			REG_UPPER_THRESH: rdata[`GLITC_POWER_W-1:0] = threshold[1];
			REG_LOWER_SCALER: rdata[`GLITC_SCALER_W-1:0] = latched[0];
			REG_UPPER_SCALER: rdata[`GLITC_SCALER_W-1:0] = latched[1];
			REG_LAST_CORR: begin
				rdata[`GLITC_CORR_W-1:0]  = last_corr[0];
				rdata[8 +: `GLITC_CORR_W] = last_corr[1];
			end
			default: rdata = '0;
		endcase
	end

	assign bus.trigger_rdata = rdata;

endmodule

// ==== design/glitc_control_registers.sv ====
//////////////////////////////////////////////////
// Command register is write-only and reads zero.
// Both command bits give one-cycle pulses.
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "glitc_config.svh"

module glitc_control_registers import glitc_pkg::*; (
	input  logic user_clk_i,
	input  logic reset_i,
	glitc_user_bus_if.ctrl bus,
	output logic soft_reset_o,
	output logic hsk_update_o
);

	localparam logic [3:0] REG_VERSION = 4'd0;
	localparam logic [3:0] REG_SCRATCH = 4'd1;
	localparam logic [3:0] REG_COMMAND = 4'd2;

	user_data_t scratch;
	logic       wr_ctrl;

	assign wr_ctrl = bus.sel_ctrl && bus.wr;

	always_comb begin
		case (bus.reg_addr)
			REG_VERSION: bus.ctrl_rdata = `GLITC_VERSION;
			REG_SCRATCH: bus.ctrl_rdata = scratch;
			default:     bus.ctrl_rdata = '0;
		endcase
	end

	always_ff @(posedge user_clk_i) begin
		if (reset_i) begin
			scratch      <= '0;
			soft_reset_o <= 1'b0;
			hsk_update_o <= 1'b0;
		end else begin
			soft_reset_o <= 1'b0;
			hsk_update_o <= 1'b0;
			if (wr_ctrl && (bus.reg_addr == REG_SCRATCH)) begin
				scratch <= bus.wdata;
			end
			// Bit 0 is soft reset, bit 1 is housekeeping update.
			if (wr_ctrl && (bus.reg_addr == REG_COMMAND)) begin
				soft_reset_o <= bus.wdata[0];
				hsk_update_o <= bus.wdata[1];
			end
		end
	end

endmodule

// ==== design/glitcbus_slave.sv ====
//////////////////////////////////////////////////
// Host must hold wr, addr and wdata stable while
// req is high. One access per request; ack stays
// high until req falls.
//////////////////////////////////////////////////
`timescale 1ns/1ps

module glitcbus_slave import glitc_pkg::*; (
	input  logic       user_clk_i,
	input  logic       reset_i,
	input  logic       req_i,
	input  logic       wr_i,
	input  user_addr_t addr_i,
	input  user_data_t wdata_i,
	output logic       ack_o,
	output user_data_t rdata_o,
	glitc_user_bus_if.slave bus
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ACCESS,
		ST_ACK
	} state_t;

	state_t     state;
	logic       req_q;
	block_t     blk;
	user_data_t rdata_mux;

	//////////////////////////////////////////////////
	// Address decode.
	//////////////////////////////////////////////////
	assign blk             = block_t'(addr_i[7:4]);
	assign bus.sel_ctrl    = (blk == BLK_CTRL);
	assign bus.sel_trigger = (blk == BLK_TRIGGER);
	assign bus.reg_addr    = addr_i[3:0];
	assign bus.wdata       = wdata_i;

	// Unpopulated blocks read as zero.
	always_comb begin
		case (blk)
			BLK_CTRL:    rdata_mux = bus.ctrl_rdata;
			BLK_TRIGGER: rdata_mux = bus.trigger_rdata;
			default:     rdata_mux = '0;
		endcase
	end

	//////////////////////////////////////////////////
	// Handshake FSM.
	//////////////////////////////////////////////////
	always_ff @(posedge user_clk_i) begin
		if (reset_i) begin
			req_q  <= 1'b0;
			state  <= ST_IDLE;
			ack_o  <= 1'b0;
			bus.wr <= 1'b0;
			bus.rd <= 1'b0;
		end else begin
			req_q  <= req_i;
			bus.wr <= 1'b0;
			bus.rd <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (req_q) begin
						state  <= ST_ACCESS;
						bus.wr <= wr_i;
						bus.rd <= !wr_i;
					end
				end
				ST_ACCESS: begin
					state <= ST_ACK;
					ack_o <= 1'b1;
				end
				ST_ACK: begin
					// Wait for the host to release the request.
					if (!req_q) begin
						state <= ST_IDLE;
						ack_o <= 1'b0;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Read data is captured during the read strobe.
	always_ff @(posedge user_clk_i) begin
		if (bus.rd) begin
			rdata_o <= rdata_mux;
		end
	end

endmodule

// ==== design/glitc_user_bus_if.sv ====
//////////////////////////////////////////////////
// Strobes last one cycle. Read data must be a
// combinational function of state and reg_addr.
//////////////////////////////////////////////////
`timescale 1ns/1ps

interface glitc_user_bus_if import glitc_pkg::*;;

	logic       sel_ctrl;
	logic       sel_trigger;
	logic [3:0] reg_addr;
	user_data_t wdata;
	logic       wr;
	logic       rd;
	user_data_t ctrl_rdata;
	user_data_t trigger_rdata;

	modport slave (
		output sel_ctrl, sel_trigger, reg_addr, wdata, wr, rd,
		input  ctrl_rdata, trigger_rdata
	);

	modport ctrl (
		input  sel_ctrl, reg_addr, wdata, wr,
		output ctrl_rdata
	);

	modport trigger (
		input  sel_trigger, reg_addr, wdata, wr,
		output trigger_rdata
	);

endinterface

// ==== design/glitc_pkg.sv ====
//////////////////////////////////////////////////
// Types shared by the register bus and trigger.
// Only blocks 0 and 7 are populated.
//////////////////////////////////////////////////
`include "glitc_config.svh"

package glitc_pkg;

	typedef logic [`GLITC_ADDR_W-1:0]   user_addr_t;
	typedef logic [`GLITC_DATA_W-1:0]   user_data_t;
	typedef logic [`GLITC_POWER_W-1:0]  power_t;
	typedef logic [`GLITC_CORR_W-1:0]   corr_t;
	typedef logic [`GLITC_SCALER_W-1:0] scaler_t;

	// Block number, taken from address bits 7 to 4.
	typedef enum logic [3:0] {
		BLK_CTRL    = 4'd0,
		BLK_TRIGGER = 4'd7
	} block_t;

endpackage

// ==== design/glitc_config.svh ====
//////////////////////////////////////////////////
// Widths assume an 8-bit address with the block
// in bits 7 to 4. The version word packs fields
// of 4, 4, 8, 4, 4 and 8 bits.
//////////////////////////////////////////////////
`ifndef GLITC_CONFIG_SVH
`define GLITC_CONFIG_SVH

`define GLITC_ADDR_W   8
`define GLITC_DATA_W   32
`define GLITC_POWER_W  12
`define GLITC_CORR_W   6
`define GLITC_SCALER_W 16

// Board rev 1, month 4, day 6, version 0.6 rev 0.
`define GLITC_VERSION  {4'd1, 4'd4, 8'd6, 4'd0, 4'd6, 8'd0}

`endif
